// ==== hw/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// address of the first instruction after reset
`define RV_RESET_PC 32'h8000_0000

// fetch FIFO entries between the fetch sequencer and decode
`define RV_FETCH_DEPTH 4

// decoded-operation FIFO entries at the output
`define RV_OP_DEPTH 2

// RV32E has 16 integer registers
`define RV_REG_BITS 4

`endif

// ==== hw/decode_pkg.sv ====
`include "rv_cfg.svh"

package decode_pkg;

	// one raw instruction word with the address it was fetched from
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
	} fetch_pkt_t;

	// bit positions inside the one-hot class vector
	typedef enum logic [3:0] {
		cls_lui    = 4'd0,
		cls_auipc  = 4'd1,
		cls_jal    = 4'd2,
		cls_jalr   = 4'd3,
		cls_branch = 4'd4,
		cls_load   = 4'd5,
		cls_store  = 4'd6,
		cls_op_imm = 4'd7,
		cls_op     = 4'd8,
		cls_system = 4'd9
	} op_class_e;

	typedef struct packed {
		logic [31:0]             pc;
		logic [9:0]              op_class; // all zero when the opcode is not recognised
		logic [2:0]              funct3;
		logic [6:0]              funct7;
		logic [`RV_REG_BITS-1:0] rd;
		logic [`RV_REG_BITS-1:0] rs1;
		logic [`RV_REG_BITS-1:0] rs2;
		logic [31:0]             imm;
		logic                    reg_wen;
		logic                    is_fencei;
		logic                    is_ecall;
		logic                    is_mret;
	} decoded_op_t;

endpackage

// ==== hw/fetch_seq.sv ====
`timescale 1ns/1ns

`include "rv_cfg.svh"

module fetch_seq (
	input  logic                   clock,
	input  logic                   rst_n,

	input  logic                   in_valid,
	input  logic [31:0]            inst,
	output logic                   in_ready,

	output logic                   out_valid,
	output decode_pkg::fetch_pkt_t out_pkt,
	input  logic                   out_ready
);

	logic [31:0] pc;
	logic        accept;

	// no storage on the data path, the handshake passes straight through
	assign in_ready  = out_ready;
	assign out_valid = in_valid;
	assign accept    = in_valid && out_ready;

	always_comb begin
		out_pkt.pc   = pc;
		out_pkt.inst = inst;
	end

	// the stream is strictly sequential since no branch ever redirects it
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `RV_RESET_PC;
		end else if (accept) begin
			pc <= pc + 32'd4;
		end
	end

endmodule

// ==== hw/pipe_fifo.sv ====
`timescale 1ns/1ns

module pipe_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clock,
	input  logic     rst_n,

	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,

	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign out_valid = (count != '0);
	assign in_ready  = (count != CNT_W'(DEPTH)) || out_ready; // a full FIFO takes a word while it is read
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;
	assign out_data  = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= ptr_next(wr_ptr);
			if (pop) rd_ptr <= ptr_next(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== hw/inst_decode.sv ====
`timescale 1ns/1ns

`include "rv_cfg.svh"

module inst_decode (
	input  logic                    clock,
	input  logic                    rst_n,

	input  logic                    in_valid,
	input  decode_pkg::fetch_pkt_t  in_pkt,
	output logic                    in_ready,

	output logic                    out_valid,
	output decode_pkg::decoded_op_t out_op,
	input  logic                    out_ready
);

	import decode_pkg::*;

	// bit positions of the instruction format vector
	localparam int FMT_R = 0;
	localparam int FMT_I = 1;
	localparam int FMT_S = 2;
	localparam int FMT_B = 3;
	localparam int FMT_U = 4;
	localparam int FMT_J = 5;

	logic [31:0] inst;
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [9:0]  op_class;
	logic [5:0]  fmt;
	logic [31:0] imm;
	logic        reg_wen;
	decoded_op_t op_next;

	assign inst   = in_pkt.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];

	always_comb begin
		op_class             = '0;
		op_class[cls_lui]    = (opcode == 7'b0110111);
		op_class[cls_auipc]  = (opcode == 7'b0010111);
		op_class[cls_jal]    = (opcode == 7'b1101111);
		op_class[cls_jalr]   = (opcode == 7'b1100111);
		op_class[cls_branch] = (opcode == 7'b1100011);
		op_class[cls_load]   = (opcode == 7'b0000011);
		op_class[cls_store]  = (opcode == 7'b0100011);
		op_class[cls_op_imm] = (opcode == 7'b0010011);
		op_class[cls_op]     = (opcode == 7'b0110011);
		op_class[cls_system] = (opcode == 7'b1110011);
	end

	always_comb begin
		fmt        = '0;
		fmt[FMT_R] = op_class[cls_op];
		fmt[FMT_I] = op_class[cls_jalr] | op_class[cls_load] | op_class[cls_op_imm] |
		             op_class[cls_system];
		fmt[FMT_S] = op_class[cls_store];
		fmt[FMT_B] = op_class[cls_branch];
		fmt[FMT_U] = op_class[cls_lui] | op_class[cls_auipc];
		fmt[FMT_J] = op_class[cls_jal];
	end

	// R format and unknown opcodes fall through to zero
	always_comb begin
		if (fmt[FMT_I]) begin
			imm = {{20{inst[31]}}, inst[31:20]};
		end else if (fmt[FMT_S]) begin
			imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		end else if (fmt[FMT_B]) begin
			imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		end else if (fmt[FMT_U]) begin
			imm = {inst[31:12], 12'b0};
		end else if (fmt[FMT_J]) begin
			imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		end else begin
			imm = '0;
		end
	end

	// ecall, ebreak and mret carry funct3 of zero and write nothing
	assign reg_wen = (fmt[FMT_I] & ~(op_class[cls_system] & (funct3 == 3'b000))) |
	                 fmt[FMT_U] | fmt[FMT_J] | fmt[FMT_R];

	always_comb begin
		op_next.pc        = in_pkt.pc;
		op_next.op_class  = op_class;
		op_next.funct3    = funct3;
		op_next.funct7    = inst[31:25];
		op_next.rd        = inst[7 +: `RV_REG_BITS]; // upper index bit is dropped for RV32E
		op_next.rs1       = inst[15 +: `RV_REG_BITS];
		op_next.rs2       = inst[20 +: `RV_REG_BITS];
		op_next.imm       = imm;
		op_next.reg_wen   = reg_wen;
		op_next.is_fencei = (opcode == 7'b0001111);
		op_next.is_ecall  = (inst == 32'h0000_0073);
		op_next.is_mret   = (inst == 32'h3020_0073);
	end

	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && in_ready) begin
			out_op <= op_next;
		end
	end

endmodule

// ==== hw/decode_front.sv ====
`timescale 1ns/1ns

`include "rv_cfg.svh"

module decode_front (
	input  logic                    clock,
	input  logic                    rst_n,

	input  logic                    in_valid,
	input  logic [31:0]             inst,
	output logic                    in_ready,

	output logic                    out_valid,
	output decode_pkg::decoded_op_t op,
	input  logic                    out_ready
);

	import decode_pkg::*;

	logic        fq_in_valid;
	fetch_pkt_t  fq_in_data;
	logic        fq_in_ready;
	logic        fq_out_valid;
	fetch_pkt_t  fq_out_data;
	logic        fq_out_ready;
	logic        dq_in_valid;
	decoded_op_t dq_in_data;
	logic        dq_in_ready;

	fetch_seq u_fetch_seq (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.inst      (inst),
		.in_ready  (in_ready),
		.out_valid (fq_in_valid),
		.out_pkt   (fq_in_data),
		.out_ready (fq_in_ready)
	);

	pipe_fifo #(
		.payload_t (fetch_pkt_t),
		.DEPTH     (`RV_FETCH_DEPTH)
	) u_fetch_fifo (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (fq_in_valid),
		.in_data   (fq_in_data),
		.in_ready  (fq_in_ready),
		.out_valid (fq_out_valid),
		.out_data  (fq_out_data),
		.out_ready (fq_out_ready)
	);

	inst_decode u_inst_decode (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (fq_out_valid),
		.in_pkt    (fq_out_data),
		.in_ready  (fq_out_ready),
		.out_valid (dq_in_valid),
		.out_op    (dq_in_data),
		.out_ready (dq_in_ready)
	);

	// drained by the consumer outside, back-pressure ripples up to in_ready
	pipe_fifo #(
		.payload_t (decoded_op_t),
		.DEPTH     (`RV_OP_DEPTH)
	) u_op_fifo (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (dq_in_valid),
		.in_data   (dq_in_data),
		.in_ready  (dq_in_ready),
		.out_valid (out_valid),
		.out_data  (op),
		.out_ready (out_ready)
	);

endmodule

// ==== tb/decode_front_assert.sv ====
`timescale 1ns/1ns

module decode_front_assert (
	input logic                    clock,
	input logic                    rst_n,
	input logic                    in_ready,
	input logic                    out_valid,
	input decode_pkg::decoded_op_t op,
	input logic                    out_ready
);

	// a stalled output stays offered and unchanged
	property hold_while_stalled;
		@(posedge clock) disable iff (!rst_n)
			(out_valid && !out_ready) |=> (out_valid && $stable(op));
	endproperty

	property class_one_hot;
		@(posedge clock) disable iff (!rst_n) out_valid |-> $onehot0(op.op_class);
	endproperty

	property ready_after_reset;
		@(posedge clock) $rose(rst_n) |-> in_ready;
	endproperty

	a_hold: assert property (hold_while_stalled)
		else $error("output changed or dropped while out_ready was low");
	a_class: assert property (class_one_hot)
		else $error("more than one op_class bit set");
	a_ready: assert property (ready_after_reset)
		else $error("in_ready low in the first cycle after reset");

endmodule

bind decode_front decode_front_assert u_front_assert (
	.clock     (clock),
	.rst_n     (rst_n),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.op        (op),
	.out_ready (out_ready)
);

// ==== tb/decode_front_tb.sv ====
`timescale 1ns/1ns

`include "rv_cfg.svh"

module decode_front_tb;

	import decode_pkg::*;

	localparam logic [31:0] SEED = 32'h8011_2c3d;

	logic        clock;
	logic        rst_n;
	logic        in_valid;
	logic [31:0] inst;
	logic        in_ready;
	logic        out_valid;
	decoded_op_t op;
	logic        out_ready;

	logic [31:0] words_q[$];
	decoded_op_t exp_q[$];
	int          n_ops;
	int          stall_at;
	int          accepted;
	int          checked;
	integer      drive_seed;
	integer      ready_seed;
	logic        loaded;

	decode_front u_decode_front (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.inst      (inst),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.op        (op),
		.out_ready (out_ready)
	);

	always #10 clock = ~clock;

	task automatic compare_value(input string name, input logic [31:0] got,
	                             input logic [31:0] expected);
		assert (got === expected) else begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, expected);
			$display("Simulation failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic load_trace();
		int          fd;
		int          rc;
		string       line;
		logic [31:0] w, cls, f3, f7, rd, rs1, rs2, imm, wen, fi, ec, mr;
		decoded_op_t e;
		fd = $fopen("tb/decode_trace.txt", "r");
		assert (fd != 0) else begin
			$display("could not open the trace file tb/decode_trace.txt");
			$display("Simulation failed");
			$fatal(1, "no trace");
		end
		while ($fgets(line, fd) != 0) begin
			rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
			             w, cls, f3, f7, rd, rs1, rs2, imm, wen, fi, ec, mr);
			if (rc == 12) begin
				e           = '0; // pc is filled in when the operation comes out
				e.op_class  = cls[9:0];
				e.funct3    = f3[2:0];
				e.funct7    = f7[6:0];
				e.rd        = rd[`RV_REG_BITS-1:0];
				e.rs1       = rs1[`RV_REG_BITS-1:0];
				e.rs2       = rs2[`RV_REG_BITS-1:0];
				e.imm       = imm;
				e.reg_wen   = wen[0];
				e.is_fencei = fi[0];
				e.is_ecall  = ec[0];
				e.is_mret   = mr[0];
				words_q.push_back(w);
				exp_q.push_back(e);
			end else begin
				assert (rc <= 0) else begin
					$display("malformed trace line: %s", line);
					$display("Simulation failed");
					$fatal(1, "bad trace");
				end
			end
		end
		$fclose(fd);
		n_ops = exp_q.size();
	endtask

	initial begin : run_test
		clock      = 1'b0;
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		inst       = '0;
		out_ready  = 1'b0;
		accepted   = 0;
		checked    = 0;
		loaded     = 1'b0;
		drive_seed = SEED;
		ready_seed = ~SEED; // keeps the two random streams apart
		load_trace();
		assert (n_ops > 0) else begin
			$display("the trace file holds no instructions");
			$display("Simulation failed");
			$fatal(1, "empty trace");
		end
		stall_at = (n_ops * 6) / 10;
		loaded   = 1'b1;
		repeat (5) @(posedge clock);
		#1;
		rst_n = 1'b1;
		wait (checked == n_ops);
		repeat (10) @(posedge clock); // a stray extra output would still hit the checker here
		if (out_valid === 1'b0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("an operation with pc %h was offered after the last expected one", op.pc);
			$display("Simulation failed");
			$fatal(1, "extra output");
		end
	end

	// out_valid low and in_ready high all through reset and one cycle past it
	initial begin : check_reset_state
		@(posedge clock);
		@(negedge clock);
		while (rst_n !== 1'b1) begin
			compare_value("out_valid", out_valid, 32'd0);
			compare_value("in_ready", in_ready, 32'd1);
			@(negedge clock);
		end
		compare_value("out_valid", out_valid, 32'd0);
		compare_value("in_ready", in_ready, 32'd1);
	end

	initial begin : drive_words
		int   sent;
		logic xfer;
		sent = 0;
		wait (rst_n === 1'b1);
		while (sent < n_ops) begin
			@(posedge clock);
			xfer = in_valid && in_ready;
			#1;
			if (xfer) begin
				sent++;
				in_valid = 1'b0;
			end
			if (!in_valid && sent < n_ops && ($random(drive_seed) & 7) != 0) begin
				in_valid = 1'b1;
				inst     = words_q[sent];
			end
		end
	end

	initial begin : drive_ready
		logic stall_done;
		stall_done = 1'b0;
		wait (rst_n === 1'b1);
		forever begin
			@(posedge clock);
			#1;
			if (!stall_done && checked >= stall_at) begin
				stall_done = 1'b1;
				out_ready  = 1'b0;
				repeat (20) @(posedge clock);
				#1;
				// both FIFOs and the decode register are full by now
				compare_value("in_ready", in_ready, 32'd0);
				compare_value("words in flight", accepted - checked,
				              `RV_OP_DEPTH + 1 + `RV_FETCH_DEPTH);
			end
			out_ready = ($unsigned($random(ready_seed)) % 100) < 70;
		end
	end

	always @(posedge clock) begin
		if (rst_n && in_valid && in_ready) begin
			accepted++;
		end
	end

	always @(posedge clock) begin : check_output
		decoded_op_t e;
		if (rst_n && out_valid && out_ready) begin
			assert (exp_q.size() != 0) else begin
				$display("an operation with pc %h came out after the trace was used up", op.pc);
				$display("Simulation failed");
				$fatal(1, "extra output");
			end
			e    = exp_q.pop_front();
			e.pc = `RV_RESET_PC + 32'(4 * checked);
			compare_value("pc", op.pc, e.pc);
			compare_value("op_class", op.op_class, e.op_class);
			compare_value("funct3", op.funct3, e.funct3);
			compare_value("funct7", op.funct7, e.funct7);
			compare_value("rd", op.rd, e.rd);
			compare_value("rs1", op.rs1, e.rs1);
			compare_value("rs2", op.rs2, e.rs2);
			compare_value("imm", op.imm, e.imm);
			compare_value("reg_wen", op.reg_wen, e.reg_wen);
			compare_value("is_fencei", op.is_fencei, e.is_fencei);
			compare_value("is_ecall", op.is_ecall, e.is_ecall);
			compare_value("is_mret", op.is_mret, e.is_mret);
			checked++;
		end
	end

	initial begin : watchdog
		wait (loaded);
		repeat ((40 * n_ops) + 200) @(posedge clock);
		$display("timeout: decoded operations stopped arriving after %0d of %0d", checked, n_ops);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== tb/decode_trace.txt ====
# word class funct3 funct7 rd rs1 rs2 imm reg_wen is_fencei is_ecall is_mret, all hex
# register indices are the low four bits of the encoded fields
123452B7 001 5 09 5 8 3 12345000 1 0 0 0  # lui x5, 0x12345
FFFFF897 002 7 7F 1 F F FFFFF000 1 0 0 0  # auipc x17, 0xfffff
001000EF 004 0 00 1 0 1 00000800 1 0 0 0  # jal x1, +2048
FFDFF06F 004 7 7F 0 F D FFFFFFFC 1 0 0 0  # jal x0, -4
FF818167 008 0 7F 2 3 8 FFFFFFF8 1 0 0 0  # jalr x2, -8(x3)
00208863 010 0 00 0 1 2 00000010 0 0 0 0  # beq x1, x2, +16
FE6290E3 010 1 7F 1 5 6 FFFFFFE0 0 0 0 0  # bne x5, x6, -32
7EE7FFE3 010 7 3F F F E 00000FFE 0 0 0 0  # bgeu x15, x14, +4094
00C12503 020 2 00 A 2 C 0000000C 1 0 0 0  # lw x10, 12(x2)
FFFFCA03 020 4 7F 4 F F FFFFFFFF 1 0 0 0  # lbu x20, -1(x31)
02742223 040 2 01 4 8 7 00000024 0 0 0 0  # sw x7, 36(x8)
F8908E23 040 0 7C C 1 9 FFFFFF9C 0 0 0 0  # sb x9, -100(x1)
7FF20193 080 0 3F 3 4 F 000007FF 1 0 0 0  # addi x3, x4, 2047
80008093 080 0 40 1 1 0 FFFFF800 1 0 0 0  # addi x1, x1, -2048
4033D313 080 5 20 6 7 3 00000403 1 0 0 0  # srai x6, x7, 3
00D605B3 100 0 00 B C D 00000000 1 0 0 0  # add x11, x12, x13
41498933 100 0 20 2 3 4 00000000 1 0 0 0  # sub x18, x19, x20
00000073 200 0 00 0 0 0 00000000 0 0 1 0  # ecall
30200073 200 0 18 0 0 2 00000302 0 0 0 1  # mret
300022F3 200 2 18 5 0 0 00000300 1 0 0 0  # csrrs x5, mstatus, x0
00100073 200 0 00 0 0 1 00000001 0 0 0 0  # ebreak
0000100F 000 1 00 0 0 0 00000000 0 1 0 0  # fence.i
FFFFFFFF 000 7 7F F F F 00000000 0 0 0 0  # unknown opcode 0x7f
1234565B 000 5 09 C 8 3 00000000 0 0 0 0  # custom-2 opcode, not decoded
00001017 002 1 00 0 0 0 00001000 1 0 0 0  # auipc x0, 0x1
80000FB7 001 0 40 F 0 0 80000000 1 0 0 0  # lui x31, 0x80000

// ==== compile.f ====
+incdir+hw
hw/decode_pkg.sv
hw/fetch_seq.sv
hw/pipe_fifo.sv
hw/inst_decode.sv
hw/decode_front.sv
tb/decode_front_assert.sv
tb/decode_front_tb.sv
